// File: source/ntps_pkg.sv
// NTP server register side: shared bus, register and time types

package ntps_pkg;

  // ----------------------------------------
  // Basic words
  // ----------------------------------------
  typedef logic [31:0] reg_word_t;

  // NTP timestamp, seconds in the upper word
  typedef struct packed {
    logic [31:0] seconds;
    logic [31:0] fraction;
  } ntp_time_t;

  // ----------------------------------------
  // Bus slot map
  // ----------------------------------------
  typedef enum logic [3:0] {
    SLOT_NTPA    = 4'd0,
    SLOT_NTPB    = 4'd1,
    SLOT_ETHLITE = 4'd2,
    SLOT_NP0     = 4'd3,
    SLOT_NP1     = 4'd4,
    SLOT_NP2     = 4'd5,
    SLOT_NP3     = 4'd6,
    SLOT_PVT     = 4'd7,
    SLOT_KEY0    = 4'd8,
    SLOT_KEY1    = 4'd9,
    SLOT_KEY2    = 4'd10,
    SLOT_KEY3    = 4'd11
  } slot_e;

  // Word offsets inside a network-path slot
  typedef enum logic [5:0] {
    NP_GEN_CONFIG = 6'd0,
    NP_NTP_CONFIG = 6'd1,
    NP_ROOT_DELAY = 6'd2,
    NP_ROOT_DISP  = 6'd3,
    NP_REF_ID     = 6'd4,
    NP_REF_TS_HI  = 6'd5,
    NP_REF_TS_LO  = 6'd6,
    NP_RX_OFS     = 6'd7,
    NP_TX_OFS     = 6'd8,
    NP_PP_STATUS  = 6'd9,
    NP_SYNC_OK    = 6'd10
  } np_reg_e;

  // Build info slot
  typedef enum logic [5:0] {
    PVT_BUILD_INFO = 6'd0,
    PVT_GIT_HASH   = 6'd1
  } pvt_reg_e;

  // ----------------------------------------
  // Field positions
  // ----------------------------------------
  localparam int GEN_CLK_SEL_BIT = 24;
  localparam int SYNC_OK_BIT     = 0;

  // ----------------------------------------
  // Bus request and response
  // ----------------------------------------
  typedef struct packed {
    logic      cs;
    logic      we;
    slot_e     slot;
    logic [5:0] offset;
    reg_word_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic      valid;
    reg_word_t rdata;
  } reg_rsp_t;

  // Writable registers of one port, as seen by the packet processor
  typedef struct packed {
    reg_word_t gen_config;
    reg_word_t ntp_config;
    reg_word_t root_delay;
    reg_word_t root_disp;
    reg_word_t ref_id;
    ntp_time_t ref_ts;
    reg_word_t rx_ofs;
    reg_word_t tx_ofs;
  } port_cfg_t;

  // One NTP time source
  typedef struct packed {
    ntp_time_t ntp_time;
    logic      upd;
    logic      sync_ok;
  } ntp_src_t;

endpackage

// File: source/reg_bus_fabric.sv
// Register bus fabric: slot decode, build info slot and registered response
`timescale 1ns/1ps

module reg_bus_fabric #(
  parameter int          NUM_PORTS  = 4,
  parameter logic [31:0] BUILD_INFO = 32'h0,
  parameter logic [31:0] GIT_HASH   = 32'h0
) (
  input  logic                clk156,
  input  logic                rst_n,
  input  ntps_pkg::reg_req_t  reg_req,
  output logic [NUM_PORTS-1:0] port_sel,
  input  ntps_pkg::reg_word_t port_rdata [NUM_PORTS],
  output ntps_pkg::reg_rsp_t  reg_rsp
);

  import ntps_pkg::*;

  logic [NUM_PORTS-1:0] port_hit;
  reg_word_t            rd_word;
  reg_rsp_t             rsp_q;

  // ----------------------------------------
  // Slot decode
  // ----------------------------------------
  // Network-path ports sit on consecutive slots from SLOT_NP0
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port_dec
    localparam logic [3:0] PORT_SLOT = 4'(SLOT_NP0) + 4'(i);

    assign port_hit[i] = (reg_req.slot == slot_e'(PORT_SLOT));
    assign port_sel[i] = reg_req.cs && port_hit[i];
  end

  // ----------------------------------------
  // Read source mux
  // ----------------------------------------
  always_comb begin
    rd_word = '0;
    if (reg_req.slot == SLOT_PVT) begin
      case (reg_req.offset)
        PVT_BUILD_INFO: rd_word = BUILD_INFO;
        PVT_GIT_HASH:   rd_word = GIT_HASH;
        default:        rd_word = '0;
      endcase
    end else begin
      // Clock, Ethernet-lite and key slots are not populated and stay zero
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (port_hit[i]) begin
          rd_word = port_rdata[i];
        end
      end
    end
  end

  // ----------------------------------------
  // Response register
  // ----------------------------------------
  always_ff @(posedge clk156) begin
    if (!rst_n) begin
      rsp_q <= '0;
    end else begin
      rsp_q.valid <= reg_req.cs;
      // Writes answer with a zero word
      rsp_q.rdata <= (reg_req.cs && !reg_req.we) ? rd_word : '0;
    end
  end

  assign reg_rsp = rsp_q;

  // One response for every request, one cycle later
  a_rsp_follows_req : assert property (
    @(posedge clk156) disable iff (!rst_n)
    reg_rsp.valid == $past(reg_req.cs && rst_n)
  ) else $error("reg_bus_fabric: response valid does not match previous request");

endmodule

// File: source/network_path_regs.sv
// Network-path register bank: one port's NTP config and status words
`timescale 1ns/1ps

module network_path_regs (
  input  logic                clk156,
  input  logic                rst_n,
  input  logic                sel,
  input  ntps_pkg::reg_req_t  reg_req,
  input  ntps_pkg::reg_word_t pp_status,
  input  logic                ntp_sync_ok,
  output ntps_pkg::reg_word_t rdata,
  output ntps_pkg::port_cfg_t cfg
);

  import ntps_pkg::*;

  port_cfg_t cfg_q;
  logic      wr_en;

  // Bank is only written while the fabric selects it
  assign wr_en = sel && reg_req.we;

  // ----------------------------------------
  // Write decode
  // ----------------------------------------
  always_ff @(posedge clk156) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else if (wr_en) begin
      case (reg_req.offset)
        NP_GEN_CONFIG: begin
          cfg_q.gen_config <= reg_req.wdata;
        end
        NP_NTP_CONFIG: begin
          cfg_q.ntp_config <= reg_req.wdata;
        end
        NP_ROOT_DELAY: begin
          cfg_q.root_delay <= reg_req.wdata;
        end
        NP_ROOT_DISP: begin
          cfg_q.root_disp <= reg_req.wdata;
        end
        NP_REF_ID: begin
          cfg_q.ref_id <= reg_req.wdata;
        end
        // Reference timestamp is split over two words
        NP_REF_TS_HI: begin
          cfg_q.ref_ts.seconds <= reg_req.wdata;
        end
        NP_REF_TS_LO: begin
          cfg_q.ref_ts.fraction <= reg_req.wdata;
        end
        NP_RX_OFS: begin
          cfg_q.rx_ofs <= reg_req.wdata;
        end
        NP_TX_OFS: begin
          cfg_q.tx_ofs <= reg_req.wdata;
        end
        default: begin
          // Status words and holes are read only
        end
      endcase
    end
  end

  // ----------------------------------------
  // Read decode
  // ----------------------------------------
  always_comb begin
    rdata = '0;
    case (reg_req.offset)
      NP_GEN_CONFIG: rdata = cfg_q.gen_config;
      NP_NTP_CONFIG: rdata = cfg_q.ntp_config;
      NP_ROOT_DELAY: rdata = cfg_q.root_delay;
      NP_ROOT_DISP:  rdata = cfg_q.root_disp;
      NP_REF_ID:     rdata = cfg_q.ref_id;
      NP_REF_TS_HI:  rdata = cfg_q.ref_ts.seconds;
      NP_REF_TS_LO:  rdata = cfg_q.ref_ts.fraction;
      NP_RX_OFS:     rdata = cfg_q.rx_ofs;
      NP_TX_OFS:     rdata = cfg_q.tx_ofs;
      NP_PP_STATUS:  rdata = pp_status;
      NP_SYNC_OK:    rdata[SYNC_OK_BIT] = ntp_sync_ok;
      default:       rdata = '0;
    endcase
  end

  assign cfg = cfg_q;

  // Config seen by the packet processor moves only on a host write
  a_cfg_needs_write : assert property (
    @(posedge clk156) disable iff (!rst_n)
    ($past(rst_n) && !$past(wr_en)) |-> $stable(cfg)
  ) else $error("network_path_regs: cfg changed without a write");

endmodule

// File: source/ntp_clock_select.sv
// NTP clock select: picks time source A or B and registers it for all ports
`timescale 1ns/1ps

module ntp_clock_select (
  input  logic               clk156,
  input  logic               rst_n,
  input  logic               sel_b,
  input  ntps_pkg::ntp_src_t ntp_a,
  input  ntps_pkg::ntp_src_t ntp_b,
  output ntps_pkg::ntp_src_t ntp_out
);

  import ntps_pkg::*;

  ntp_src_t src_sel;
  ntp_src_t out_q;

  // ----------------------------------------
  // Source mux
  // ----------------------------------------
  // Time, update pulse and sync flag switch together
  always_comb begin
    if (sel_b) begin
      src_sel = ntp_b;
    end else begin
      src_sel = ntp_a;
    end
  end

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  always_ff @(posedge clk156) begin
    if (!rst_n) begin
      out_q <= '0;
    end else begin
      out_q <= src_sel;
    end
  end

  assign ntp_out = out_q;

  // No update pulse on the output unless the chosen source pulsed
  a_upd_from_selected : assert property (
    @(posedge clk156) disable iff (!rst_n)
    ntp_out.upd |-> $past(sel_b ? ntp_b.upd : ntp_a.upd)
  ) else $error("ntp_clock_select: update pulse not from selected source");

endmodule

// File: source/ntps_interfaces.sv
// NTP server interfaces top: register fabric, port register banks, clock select
`timescale 1ns/1ps

module ntps_interfaces #(
  parameter int          NUM_PORTS  = 4,
  parameter logic [31:0] BUILD_INFO = 32'h0,
  parameter logic [31:0] GIT_HASH   = 32'h0
) (
  input  logic                clk156,
  input  logic                rst_n,

  // Host register bus
  input  ntps_pkg::reg_req_t  reg_req,
  output ntps_pkg::reg_rsp_t  reg_rsp,

  // Packet processor side, one entry per port
  input  ntps_pkg::reg_word_t pp_status [NUM_PORTS],
  output ntps_pkg::port_cfg_t port_cfg  [NUM_PORTS],

  // NTP time sources and selected time
  input  ntps_pkg::ntp_src_t  ntp_a,
  input  ntps_pkg::ntp_src_t  ntp_b,
  output ntps_pkg::ntp_src_t  ntp_out
);

  import ntps_pkg::*;

  logic [NUM_PORTS-1:0] port_sel;
  reg_word_t            port_rdata [NUM_PORTS];

  // ----------------------------------------
  // Register bus fabric
  // ----------------------------------------
  reg_bus_fabric #(
    .NUM_PORTS  (NUM_PORTS),
    .BUILD_INFO (BUILD_INFO),
    .GIT_HASH   (GIT_HASH)
  ) u_fabric (
    .clk156     (clk156),
    .rst_n      (rst_n),
    .reg_req    (reg_req),
    .port_sel   (port_sel),
    .port_rdata (port_rdata),
    .reg_rsp    (reg_rsp)
  );

  // ----------------------------------------
  // Per-port register banks
  // ----------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_np
    network_path_regs u_np_regs (
      .clk156      (clk156),
      .rst_n       (rst_n),
      .sel         (port_sel[i]),
      .reg_req     (reg_req),
      .pp_status   (pp_status[i]),
      .ntp_sync_ok (ntp_out.sync_ok),
      .rdata       (port_rdata[i]),
      .cfg         (port_cfg[i])
    );
  end

  // ----------------------------------------
  // Common NTP clock select
  // ----------------------------------------
  // Port 0 general config owns the source choice for every port
  ntp_clock_select u_clk_sel (
    .clk156  (clk156),
    .rst_n   (rst_n),
    .sel_b   (port_cfg[0].gen_config[GEN_CLK_SEL_BIT]),
    .ntp_a   (ntp_a),
    .ntp_b   (ntp_b),
    .ntp_out (ntp_out)
  );

endmodule

// File: verif/tb_ntps_interfaces.sv
// Directed testbench for the NTP server register side top level
`timescale 1ns/1ps

module tb_ntps_interfaces;

  import ntps_pkg::*;

  localparam int          NUM_PORTS  = 4;
  localparam logic [31:0] BUILD_INFO = 32'h1a2b_3c4d;
  localparam logic [31:0] GIT_HASH   = 32'h9e8f_7a6b;
  // All tests take about 500 cycles so this leaves wide headroom
  localparam int          TIMEOUT_CYCLES = 2000;

  logic      clk156;
  logic      rst_n;
  reg_req_t  reg_req;
  reg_rsp_t  reg_rsp;
  reg_word_t pp_status [NUM_PORTS];
  port_cfg_t port_cfg  [NUM_PORTS];
  ntp_src_t  ntp_a;
  ntp_src_t  ntp_b;
  ntp_src_t  ntp_out;

  // Expected writable words per port and offset
  reg_word_t shadow [NUM_PORTS][9];
  ntp_src_t  src_a;
  ntp_src_t  src_b;
  int        seed = 32'h2ac4082b;
  int        cycle_count = 0;
  int        checks = 0;
  int        errors = 0;
  int        tests = 0;

  ntps_interfaces #(
    .NUM_PORTS  (NUM_PORTS),
    .BUILD_INFO (BUILD_INFO),
    .GIT_HASH   (GIT_HASH)
  ) u_dut (
    .clk156    (clk156),
    .rst_n     (rst_n),
    .reg_req   (reg_req),
    .reg_rsp   (reg_rsp),
    .pp_status (pp_status),
    .port_cfg  (port_cfg),
    .ntp_a     (ntp_a),
    .ntp_b     (ntp_b),
    .ntp_out   (ntp_out)
  );

  initial begin
    clk156 = 1'b0;
    forever #20 clk156 = ~clk156;
  end

  always @(posedge clk156) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic slot_e port_slot(input int p);
    return slot_e'(4'(SLOT_NP0) + 4'(p));
  endfunction

  // Expected port config with ref_ts built from the HI and LO words
  function automatic port_cfg_t expected_cfg(input int p);
    port_cfg_t c;
    c.gen_config        = shadow[p][0];
    c.ntp_config        = shadow[p][1];
    c.root_delay        = shadow[p][2];
    c.root_disp         = shadow[p][3];
    c.ref_id            = shadow[p][4];
    c.ref_ts.seconds    = shadow[p][5];
    c.ref_ts.fraction   = shadow[p][6];
    c.rx_ofs            = shadow[p][7];
    c.tx_ofs            = shadow[p][8];
    return c;
  endfunction

  task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_all_cfg();
    for (int p = 0; p < NUM_PORTS; p++) begin
      checks++;
      if (port_cfg[p] !== expected_cfg(p)) begin
        errors++;
        $display("Error: port_cfg[%0d] got %h expected %h", p, port_cfg[p], expected_cfg(p));
      end
    end
  endtask

  task automatic check_src(input ntp_src_t exp);
    checks++;
    if (ntp_out !== exp) begin
      errors++;
      $display("Error: ntp_out got %h expected %h", ntp_out, exp);
    end
  endtask

  // One request strobe and its response exactly one cycle later
  task automatic bus_access(input logic we, input slot_e slot, input logic [5:0] offset,
                            input reg_word_t wdata, output reg_word_t rdata);
    reg_req_t req;
    req.cs     = 1'b1;
    req.we     = we;
    req.slot   = slot;
    req.offset = offset;
    req.wdata  = wdata;
    @(posedge clk156);
    reg_req <= req;
    @(posedge clk156);
    reg_req <= '0;
    @(negedge clk156);
    checks++;
    if (!reg_rsp.valid) begin
      errors++;
      $display("No response one cycle after request to slot %0d offset %0d", slot, offset);
    end
    rdata = reg_rsp.rdata;
  endtask

  task automatic write_reg(input slot_e slot, input logic [5:0] offset, input reg_word_t data);
    reg_word_t rd;
    bus_access(1'b1, slot, offset, data, rd);
    check_word("reg_rsp.rdata", rd, '0);
  endtask

  task automatic read_check(input slot_e slot, input logic [5:0] offset, input reg_word_t exp);
    reg_word_t rd;
    bus_access(1'b0, slot, offset, '0, rd);
    check_word($sformatf("reg_rsp.rdata slot %0d offset %0d", slot, offset), rd, exp);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    $display("%s: %0d errors", name, errors - errs_before);
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_reset();
    int e0;
    e0 = errors;
    repeat (4) begin
      @(negedge clk156);
      checks++;
      if (reg_rsp.valid !== 1'b0) begin
        errors++;
        $display("Response valid raised while the bus is idle");
      end
    end
    check_all_cfg();
    check_src('0);
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int off = 0; off <= 10; off++) begin
        read_check(port_slot(p), 6'(off), '0);
      end
    end
    end_test("reset", e0);
  endtask

  task automatic test_read_write();
    int        e0;
    reg_word_t v;
    e0 = errors;
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int off = 0; off < 9; off++) begin
        v = $random(seed);
        write_reg(port_slot(p), 6'(off), v);
        shadow[p][off] = v;
        read_check(port_slot(p), 6'(off), v);
      end
      // Other ports must still hold their old words
      check_all_cfg();
    end
    end_test("read_write", e0);
  endtask

  task automatic test_status();
    int        e0;
    reg_word_t status_v [NUM_PORTS];
    logic      flag;
    logic      use_b;
    e0 = errors;
    @(posedge clk156);
    for (int p = 0; p < NUM_PORTS; p++) begin
      status_v[p] = $random(seed);
      pp_status[p] <= status_v[p];
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      read_check(port_slot(p), NP_PP_STATUS, status_v[p]);
      write_reg(port_slot(p), NP_PP_STATUS, $random(seed));
      read_check(port_slot(p), NP_PP_STATUS, status_v[p]);
    end
    check_all_cfg();
    // Opposite flags on the two sources so only the selected one reaches the banks
    use_b = shadow[0][0][GEN_CLK_SEL_BIT];
    for (int k = 0; k < 2; k++) begin
      flag = (k == 0);
      @(posedge clk156);
      src_a.sync_ok = flag;
      src_b.sync_ok = !flag;
      ntp_a <= src_a;
      ntp_b <= src_b;
      repeat (2) @(posedge clk156);
      for (int p = 0; p < NUM_PORTS; p++) begin
        read_check(port_slot(p), NP_SYNC_OK, {31'b0, (use_b ? !flag : flag)});
      end
    end
    end_test("status", e0);
  endtask

  task automatic test_unmapped_pvt();
    int e0;
    e0 = errors;
    for (int s = 0; s < 12; s++) begin
      if (s < 3 || s > 7) begin
        read_check(slot_e'(4'(s)), 6'd0, '0);
        read_check(slot_e'(4'(s)), 6'($random(seed)), '0);
        write_reg(slot_e'(4'(s)), 6'd0, $random(seed));
      end
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int off = 11; off < 64; off += 13) begin
        write_reg(port_slot(p), 6'(off), $random(seed));
        read_check(port_slot(p), 6'(off), '0);
      end
    end
    check_all_cfg();
    read_check(SLOT_PVT, PVT_BUILD_INFO, BUILD_INFO);
    read_check(SLOT_PVT, PVT_GIT_HASH, GIT_HASH);
    read_check(SLOT_PVT, 6'd2, '0);
    write_reg(SLOT_PVT, PVT_BUILD_INFO, $random(seed));
    read_check(SLOT_PVT, PVT_BUILD_INFO, BUILD_INFO);
    check_all_cfg();
    end_test("unmapped_pvt", e0);
  endtask

  // Output must repeat the chosen source one cycle late
  task automatic follow_source(input logic use_b, input int cycles);
    ntp_src_t prev;
    ntp_src_t a_v;
    ntp_src_t b_v;
    int       r;
    prev = use_b ? src_b : src_a;
    for (int k = 0; k < cycles; k++) begin
      r = $random(seed);
      a_v.ntp_time = {$random(seed), $random(seed)};
      a_v.upd      = r[0];
      a_v.sync_ok  = r[1];
      b_v.ntp_time = {$random(seed), $random(seed)};
      b_v.upd      = r[2];
      b_v.sync_ok  = r[3];
      @(posedge clk156);
      ntp_a <= a_v;
      ntp_b <= b_v;
      src_a = a_v;
      src_b = b_v;
      @(negedge clk156);
      check_src(prev);
      prev = use_b ? b_v : a_v;
    end
  endtask

  task automatic test_clock_select();
    int e0;
    e0 = errors;
    write_reg(port_slot(0), NP_GEN_CONFIG, 32'h0000_0000);
    shadow[0][0] = 32'h0000_0000;
    // Bit 24 on port 1 must not move the selector
    write_reg(port_slot(1), NP_GEN_CONFIG, 32'h0100_0000);
    shadow[1][0] = 32'h0100_0000;
    follow_source(1'b0, 16);
    write_reg(port_slot(0), NP_GEN_CONFIG, 32'h0100_00a5);
    shadow[0][0] = 32'h0100_00a5;
    check_all_cfg();
    follow_source(1'b1, 16);
    end_test("clock_select", e0);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int off = 0; off < 9; off++) begin
        shadow[p][off] = '0;
      end
      pp_status[p] <= '0;
    end
    src_a = '0;
    src_b = '0;
    reg_req <= '0;
    ntp_a   <= '0;
    ntp_b   <= '0;
    rst_n   <= 1'b0;
    repeat (2) @(posedge clk156);
    rst_n <= 1'b1;

    test_reset();
    test_read_write();
    test_status();
    test_unmapped_pvt();
    test_clock_select();

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: ntps_interfaces.f
source/ntps_pkg.sv
source/reg_bus_fabric.sv
source/network_path_regs.sv
source/ntp_clock_select.sv
source/ntps_interfaces.sv
verif/tb_ntps_interfaces.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the ntps_interfaces testbench with Verilator

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_ntps_interfaces \
  -f ntps_interfaces.f -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "Verilator build error"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -qx "Test passed" sim.log && exit 0 || exit 1
